//--- rtl/sw_pkg.sv
`default_nettype none

package sw_pkg;

    // datapath widths
    localparam int SCORE_W = 14;
    localparam int BASE_W  = 2;
    localparam int NUM_PE  = 8;
    localparam int ROW_W   = 3;
    localparam int COL_W   = 10;

    typedef logic signed [SCORE_W-1:0] score_t;
    typedef logic [BASE_W-1:0]         base_t;

    // last column the counter may reach
    localparam logic [COL_W-1:0] MAX_LEN = 10'd511;

    // affine gap scoring
    localparam score_t GAP_OPEN   = -12;
    localparam score_t GAP_EXTEND = -1;
    localparam score_t MATCH      = 2;
    localparam score_t MISMATCH   = -3;

    // x-drop threshold below the best score
    localparam score_t XDROP = 250;

    // minus infinity for empty cells
    localparam score_t NEG_INF = -4096;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CALC,
        ST_DONE
    } stripe_state_e;

endpackage

`default_nettype wire

//--- rtl/array_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface array_ctrl_if;

    // one-cycle load of the query that clears all cells
    logic                     load;
    logic                     run;
    // enable bit entering row 0
    logic                     feed;
    logic [sw_pkg::COL_W-1:0] col;

    modport ctrl (
        output load, run, feed, col
    );

    modport array (
        input load, run, feed, col
    );

endinterface

`default_nettype wire

//--- rtl/wavefront_if.sv
`timescale 1ns/1ps
`default_nettype none

interface wavefront_if;

    sw_pkg::score_t           v [sw_pkg::NUM_PE];
    // rows holding a cell of the current wavefront
    logic [sw_pkg::NUM_PE-1:0] en;
    logic                     last_done;
    sw_pkg::score_t           wf_max;
    logic [sw_pkg::ROW_W-1:0] wf_row;

    modport array (
        output v, en, last_done
    );

    modport tree (
        input  v, en,
        output wf_max, wf_row
    );

    modport ctrl (
        input wf_max, wf_row, last_done
    );

endinterface

`default_nettype wire

//--- rtl/sw_pe.sv
`timescale 1ns/1ps
`default_nettype none

module sw_pe (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_load,
    input  logic           i_en,
    input  sw_pkg::base_t  i_b_base,
    input  sw_pkg::base_t  i_a_base,
    input  sw_pkg::score_t i_v_top,
    input  sw_pkg::score_t i_v_diag,
    input  sw_pkg::score_t i_d_top,
    input  sw_pkg::score_t i_v_left_init,
    output sw_pkg::base_t  o_a_base,
    output logic           o_en,
    output sw_pkg::score_t o_v,
    output sw_pkg::score_t o_v_prev,
    output sw_pkg::score_t o_d
);

    sw_pkg::base_t  a_q;
    sw_pkg::base_t  b_q;
    logic           en_q;
    sw_pkg::score_t v_q;
    sw_pkg::score_t v_prev_q;
    sw_pkg::score_t i_q;
    sw_pkg::score_t d_q;
    sw_pkg::score_t i_nxt;
    sw_pkg::score_t d_nxt;
    sw_pkg::score_t v_diag;
    sw_pkg::score_t v_di;
    sw_pkg::score_t v_nxt;

    // left neighbour is this cell's own previous column
    assign i_nxt = ((v_q + sw_pkg::GAP_OPEN) > (i_q + sw_pkg::GAP_EXTEND)) ?
                   (v_q + sw_pkg::GAP_OPEN) : (i_q + sw_pkg::GAP_EXTEND);
    assign d_nxt = ((i_v_top + sw_pkg::GAP_OPEN) > (i_d_top + sw_pkg::GAP_EXTEND)) ?
                   (i_v_top + sw_pkg::GAP_OPEN) : (i_d_top + sw_pkg::GAP_EXTEND);
    assign v_diag = i_v_diag + ((a_q == b_q) ? sw_pkg::MATCH : sw_pkg::MISMATCH);
    assign v_di   = (i_nxt > v_diag) ? i_nxt : v_diag;
    assign v_nxt  = (d_nxt > v_di) ? d_nxt : v_di;

    always_ff @(posedge i_clk) begin
        a_q <= i_a_base;
        if (i_load) begin
            b_q <= i_b_base;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            en_q <= 1'b0;
        end else begin
            en_q <= i_en;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            v_q      <= sw_pkg::NEG_INF;
            v_prev_q <= sw_pkg::NEG_INF;
            i_q      <= sw_pkg::NEG_INF;
            d_q      <= sw_pkg::NEG_INF;
        end else if (i_load) begin
            v_q      <= i_v_left_init;
            v_prev_q <= i_v_left_init;
            i_q      <= sw_pkg::NEG_INF;
            d_q      <= sw_pkg::NEG_INF;
        end else if (en_q) begin
            v_q      <= v_nxt;
            // old V becomes the diagonal of the row below
            v_prev_q <= v_q;
            i_q      <= i_nxt;
            d_q      <= d_nxt;
        end
    end

    assign o_a_base = a_q;
    assign o_en     = en_q;
    assign o_v      = v_q;
    assign o_v_prev = v_prev_q;
    assign o_d      = d_q;

    a_v_floor: assert property (@(posedge i_clk) disable iff (i_rst)
        v_q >= sw_pkg::NEG_INF)
        else $error("V score fell below minus infinity");

endmodule

`default_nettype wire

//--- rtl/sw_pe_array.sv
`timescale 1ns/1ps
`default_nettype none

module sw_pe_array (
    input  logic                                     i_clk,
    input  logic                                     i_rst,
    input  sw_pkg::base_t                            i_a,
    input  logic [sw_pkg::NUM_PE*sw_pkg::BASE_W-1:0] i_b,
    array_ctrl_if.array                              ctl,
    wavefront_if.array                               wf
);

    sw_pkg::base_t             a_vec [sw_pkg::NUM_PE];
    sw_pkg::score_t            v_vec [sw_pkg::NUM_PE];
    sw_pkg::score_t            v_prev_vec [sw_pkg::NUM_PE];
    sw_pkg::score_t            d_vec [sw_pkg::NUM_PE];
    logic [sw_pkg::NUM_PE-1:0] en_vec;
    logic [sw_pkg::NUM_PE-1:0] en_low;
    logic [sw_pkg::NUM_PE-1:0] valid_q;
    sw_pkg::score_t            col_s;
    sw_pkg::score_t            top_row0;
    sw_pkg::score_t            diag_row0;

    // top boundary row -1 of the first stripe
    assign col_s     = sw_pkg::score_t'(ctl.col);
    assign top_row0  = sw_pkg::GAP_OPEN + sw_pkg::GAP_EXTEND * (col_s + sw_pkg::score_t'(1));
    assign diag_row0 = (ctl.col == '0) ? '0 : sw_pkg::GAP_OPEN + sw_pkg::GAP_EXTEND * col_s;

    for (genvar gi = 0; gi < sw_pkg::NUM_PE; gi++) begin : g_pe
        sw_pkg::base_t  a_in;
        logic           en_in;
        sw_pkg::score_t v_top;
        sw_pkg::score_t v_diag;
        sw_pkg::score_t d_top;
        sw_pkg::score_t left_init;

        if (gi == 0) begin : g_first
            assign a_in   = i_a;
            assign en_in  = ctl.feed;
            assign v_top  = top_row0;
            assign v_diag = diag_row0;
            assign d_top  = sw_pkg::NEG_INF;
        end else begin : g_next
            assign a_in   = a_vec[gi-1];
            // chain only shifts while calculating
            assign en_in  = en_vec[gi-1] & ctl.run;
            assign v_top  = v_vec[gi-1];
            assign v_diag = v_prev_vec[gi-1];
            assign d_top  = d_vec[gi-1];
        end

        assign left_init = sw_pkg::score_t'(sw_pkg::GAP_OPEN + sw_pkg::GAP_EXTEND * (gi + 1));

        sw_pe u_pe (
            .i_clk         (i_clk),
            .i_rst         (i_rst),
            .i_load        (ctl.load),
            .i_en          (en_in),
            .i_b_base      (i_b[gi*sw_pkg::BASE_W +: sw_pkg::BASE_W]),
            .i_a_base      (a_in),
            .i_v_top       (v_top),
            .i_v_diag      (v_diag),
            .i_d_top       (d_top),
            .i_v_left_init (left_init),
            .o_a_base      (a_vec[gi]),
            .o_en          (en_vec[gi]),
            .o_v           (v_vec[gi]),
            .o_v_prev      (v_prev_vec[gi]),
            .o_d           (d_vec[gi])
        );

        assign wf.v[gi] = v_vec[gi];
    end

    // rows that updated on the last edge
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            valid_q <= '0;
        end else begin
            valid_q <= ctl.run ? en_vec : '0;
        end
    end

    assign wf.en        = valid_q;
    assign wf.last_done = valid_q[sw_pkg::NUM_PE-1] & ~en_vec[sw_pkg::NUM_PE-1];

    // lowest set bit of the enable chain
    assign en_low = en_vec & (~en_vec + 1'b1);

    a_en_contig: assert property (@(posedge i_clk) disable iff (i_rst)
        ((en_vec + en_low) & en_vec) == '0)
        else $error("enable chain has a gap");

endmodule

`default_nettype wire

//--- rtl/wavefront_max_tree.sv
`timescale 1ns/1ps
`default_nettype none

module wavefront_max_tree (
    wavefront_if.tree wf
);

    // node k has children 2k+1 and 2k+2
    sw_pkg::score_t           node_v [2*sw_pkg::NUM_PE-1];
    logic [sw_pkg::ROW_W-1:0] node_r [2*sw_pkg::NUM_PE-1];

    always_comb begin
        // idle rows sit at minus infinity
        for (int i = 0; i < sw_pkg::NUM_PE; i++) begin
            node_v[sw_pkg::NUM_PE-1+i] = wf.en[i] ? wf.v[i] : sw_pkg::NEG_INF;
            node_r[sw_pkg::NUM_PE-1+i] = sw_pkg::ROW_W'(i);
        end
        // lower row must be strictly greater to win
        for (int k = sw_pkg::NUM_PE - 2; k >= 0; k--) begin
            if (node_v[2*k+1] > node_v[2*k+2]) begin
                node_v[k] = node_v[2*k+1];
                node_r[k] = node_r[2*k+1];
            end else begin
                node_v[k] = node_v[2*k+2];
                node_r[k] = node_r[2*k+2];
            end
        end
    end

    assign wf.wf_max = node_v[0];
    assign wf.wf_row = node_r[0];

endmodule

`default_nettype wire

//--- rtl/stripe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module stripe_ctrl (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic                     i_start,
    array_ctrl_if.ctrl               ctl,
    wavefront_if.ctrl                wf,
    output logic                     o_stripe_end,
    output sw_pkg::score_t           o_max_score,
    output logic [sw_pkg::ROW_W-1:0] o_max_row,
    output logic [sw_pkg::COL_W-1:0] o_max_col,
    output logic [sw_pkg::COL_W-1:0] o_stop_diag
);

    sw_pkg::stripe_state_e    state_q;
    logic [sw_pkg::COL_W-1:0] col_q;
    logic [sw_pkg::COL_W-1:0] diag_t;
    logic [sw_pkg::COL_W-1:0] best_col_q;
    logic [sw_pkg::COL_W-1:0] stop_diag_q;
    logic [sw_pkg::ROW_W-1:0] best_row_q;
    sw_pkg::score_t           best_q;
    sw_pkg::score_t           drop_lvl;
    logic                     load;
    logic                     run;
    logic                     eval;
    logic                     xdrop;
    logic                     better;
    logic                     stop_now;
    logic                     end_q;

    assign load = (state_q == sw_pkg::ST_IDLE) && i_start;
    assign run  = (state_q == sw_pkg::ST_CALC);

    // wavefront t is visible while the counter reads t+1
    assign eval   = run && (col_q != '0);
    assign diag_t = col_q - 1'b1;

    assign drop_lvl = best_q - sw_pkg::XDROP;
    assign xdrop    = wf.wf_max < drop_lvl;
    assign better   = eval && (wf.wf_max > best_q);
    assign stop_now = eval && (wf.last_done || xdrop || (col_q == sw_pkg::MAX_LEN));

    assign ctl.load = load;
    assign ctl.run  = run;
    assign ctl.feed = i_start && (load || (run && !stop_now));
    assign ctl.col  = col_q;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q     <= sw_pkg::ST_IDLE;
            col_q       <= '0;
            best_q      <= sw_pkg::NEG_INF;
            best_row_q  <= '0;
            best_col_q  <= '0;
            stop_diag_q <= '0;
            end_q       <= 1'b0;
        end else begin
            end_q <= stop_now;
            case (state_q)
                sw_pkg::ST_IDLE: begin
                    if (i_start) begin
                        state_q     <= sw_pkg::ST_CALC;
                        col_q       <= '0;
                        best_q      <= sw_pkg::NEG_INF;
                        best_row_q  <= '0;
                        best_col_q  <= '0;
                        stop_diag_q <= '0;
                    end
                end
                sw_pkg::ST_CALC: begin
                    col_q <= col_q + 1'b1;
                    // strict compare keeps the earliest wavefront
                    if (better) begin
                        best_q     <= wf.wf_max;
                        best_row_q <= wf.wf_row;
                        best_col_q <= diag_t - {{(sw_pkg::COL_W-sw_pkg::ROW_W){1'b0}}, wf.wf_row};
                    end
                    if (stop_now) begin
                        state_q     <= sw_pkg::ST_DONE;
                        stop_diag_q <= diag_t;
                    end
                end
                sw_pkg::ST_DONE: begin
                    state_q <= sw_pkg::ST_IDLE;
                end
                default: begin
                    state_q <= sw_pkg::ST_IDLE;
                end
            endcase
        end
    end

    assign o_stripe_end = end_q;
    assign o_max_score  = best_q;
    assign o_max_row    = best_row_q;
    assign o_max_col    = best_col_q;
    assign o_stop_diag  = stop_diag_q;

    a_end_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        o_stripe_end |=> !o_stripe_end)
        else $error("stripe end held for more than one cycle");

endmodule

`default_nettype wire

//--- rtl/sw_stripe_top.sv
`timescale 1ns/1ps
`default_nettype none

module sw_stripe_top (
    input  logic                                     i_clk,
    input  logic                                     i_rst,
    input  logic                                     i_start,
    input  sw_pkg::base_t                            i_a,
    input  logic [sw_pkg::NUM_PE*sw_pkg::BASE_W-1:0] i_b,
    output logic                                     o_stripe_end,
    output sw_pkg::score_t                           o_max_score,
    output logic [sw_pkg::ROW_W-1:0]                 o_max_row,
    output logic [sw_pkg::COL_W-1:0]                 o_max_col,
    output logic [sw_pkg::COL_W-1:0]                 o_stop_diag
);

    array_ctrl_if ctl_if ();
    wavefront_if  wf_if ();

    sw_pe_array u_array (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_a   (i_a),
        .i_b   (i_b),
        .ctl   (ctl_if.array),
        .wf    (wf_if.array)
    );

    wavefront_max_tree u_tree (
        .wf (wf_if.tree)
    );

    stripe_ctrl u_ctrl (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_start      (i_start),
        .ctl          (ctl_if.ctrl),
        .wf           (wf_if.ctrl),
        .o_stripe_end (o_stripe_end),
        .o_max_score  (o_max_score),
        .o_max_row    (o_max_row),
        .o_max_col    (o_max_col),
        .o_stop_diag  (o_stop_diag)
    );

endmodule

`default_nettype wire

//--- tests/sw_ref_model.svh
`ifndef SW_REF_MODEL_SVH
`define SW_REF_MODEL_SVH
`default_nettype none

// longest reference the model holds
localparam int MAX_COLS = 640;

// 32-bit linear congruential step
function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic int max2(input int x, input int y);
    return (x > y) ? x : y;
endfunction

// full band DP followed by a walk over the wavefronts
function automatic void align_model(
    input  sw_pkg::base_t q [sw_pkg::NUM_PE],
    input  sw_pkg::base_t a [MAX_COLS],
    input  int            len,
    output int            e_score,
    output int            e_row,
    output int            e_col,
    output int            e_diag
);
    int  v [sw_pkg::NUM_PE][MAX_COLS];
    int  iv [sw_pkg::NUM_PE][MAX_COLS];
    int  dv [sw_pkg::NUM_PE][MAX_COLS];
    int  go;
    int  ge;
    int  neg;
    int  v_left;
    int  i_left;
    int  v_top;
    int  d_top;
    int  v_diag;
    int  s;
    int  wmax;
    int  wrow;
    bit  stop;
    bit  done;

    go  = sw_pkg::GAP_OPEN;
    ge  = sw_pkg::GAP_EXTEND;
    neg = sw_pkg::NEG_INF;
    for (int c = 0; c < len; c++) begin
        for (int r = 0; r < sw_pkg::NUM_PE; r++) begin
            v_left = (c == 0) ? go + ge * (r + 1) : v[r][c-1];
            i_left = (c == 0) ? neg : iv[r][c-1];
            if (r == 0) begin
                v_top  = go + ge * (c + 1);
                d_top  = neg;
                v_diag = (c == 0) ? 0 : go + ge * c;
            end else begin
                v_top  = v[r-1][c];
                d_top  = dv[r-1][c];
                v_diag = (c == 0) ? go + ge * r : v[r-1][c-1];
            end
            s = (q[r] == a[c]) ? int'(sw_pkg::MATCH) : int'(sw_pkg::MISMATCH);
            iv[r][c] = max2(v_left + go, i_left + ge);
            dv[r][c] = max2(v_top + go, d_top + ge);
            v[r][c]  = max2(v_diag + s, max2(iv[r][c], dv[r][c]));
        end
    end

    e_score = neg;
    e_row   = 0;
    e_col   = 0;
    e_diag  = 0;
    done    = 1'b0;
    for (int t = 0; t < len + sw_pkg::NUM_PE && !done; t++) begin
        wmax = neg - 1;
        wrow = 0;
        // >= hands a tie to the higher row
        for (int r = 0; r < sw_pkg::NUM_PE; r++) begin
            if (t - r >= 0 && t - r < len && v[r][t-r] >= wmax) begin
                wmax = v[r][t-r];
                wrow = r;
            end
        end
        stop = (t == len + sw_pkg::NUM_PE - 2) || (wmax < e_score - int'(sw_pkg::XDROP)) ||
               (t + 1 == int'(sw_pkg::MAX_LEN));
        if (wmax > e_score) begin
            e_score = wmax;
            e_row   = wrow;
            e_col   = t - wrow;
        end
        if (stop) begin
            done   = 1'b1;
            e_diag = t;
        end
    end
endfunction

`default_nettype wire
`endif

//--- tests/tb_sw_stripe.sv
`timescale 1ns/1ps
`include "sw_ref_model.svh"
`default_nettype none

module tb_sw_stripe;

    localparam int          NUM_TESTS  = 9;
    localparam int          RST_CYCLES = 16;
    localparam logic [31:0] SEED       = 32'hc950_70ed;
    localparam int          REF_COPY   = 0;
    localparam int          REF_MISS   = 1;
    localparam int          REF_RAND   = 2;
    localparam int          CHK_NONE   = 0;
    localparam int          CHK_IDENT  = 1;
    localparam int          CHK_EARLY  = 2;

    logic                                     i_clk;
    logic                                     i_rst;
    logic                                     i_start;
    sw_pkg::base_t                            i_a;
    logic [sw_pkg::NUM_PE*sw_pkg::BASE_W-1:0] i_b;
    logic                                     o_stripe_end;
    sw_pkg::score_t                           o_max_score;
    logic [sw_pkg::ROW_W-1:0]                 o_max_row;
    logic [sw_pkg::COL_W-1:0]                 o_max_col;
    logic [sw_pkg::COL_W-1:0]                 o_stop_diag;

    // test table
    string       t_name [NUM_TESTS];
    int          t_len [NUM_TESTS];
    bit          t_qfix [NUM_TESTS];
    logic [15:0] t_qval [NUM_TESTS];
    int          t_kind [NUM_TESTS];
    int          t_seed_ofs [NUM_TESTS];
    int          t_chk [NUM_TESTS];

    sw_pkg::base_t qry [sw_pkg::NUM_PE];
    sw_pkg::base_t refs [MAX_COLS];
    logic [31:0]   lcg_state;
    int            n_pass;
    int            n_fail;
    int            reset_errs;
    int            budget;
    int            cycle_cnt = 0;

    sw_stripe_top dut_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_start      (i_start),
        .i_a          (i_a),
        .i_b          (i_b),
        .o_stripe_end (o_stripe_end),
        .o_max_score  (o_max_score),
        .o_max_row    (o_max_row),
        .o_max_col    (o_max_col),
        .o_stop_diag  (o_stop_diag)
    );

    always #20 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= budget) begin
            $display("timeout after %0d cycles, the run never finished", cycle_cnt);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic add_test(input int n, input string name, input int len, input bit qfix,
                            input logic [15:0] qval, input int kind, input int ofs,
                            input int chk);
        t_name[n]     = name;
        t_len[n]      = len;
        t_qfix[n]     = qfix;
        t_qval[n]     = qval;
        t_kind[n]     = kind;
        t_seed_ofs[n] = ofs;
        t_chk[n]      = chk;
    endtask

    task automatic build_table();
        add_test(0, "ident", 8, 1'b0, 16'h0000, REF_COPY, 1, CHK_IDENT);
        add_test(1, "rand_len5", 5, 1'b0, 16'h0000, REF_RAND, 2, CHK_NONE);
        add_test(2, "copy_len20", 20, 1'b0, 16'h0000, REF_COPY, 3, CHK_NONE);
        add_test(3, "single_base", 1, 1'b0, 16'h0000, REF_RAND, 4, CHK_NONE);
        add_test(4, "rand_len64", 64, 1'b0, 16'h0000, REF_RAND, 5, CHK_NONE);
        // all-zero query against reference bases 1 to 3
        add_test(5, "all_mismatch", 400, 1'b1, 16'h0000, REF_MISS, 6, CHK_EARLY);
        add_test(6, "past_max_len", 600, 1'b0, 16'h0000, REF_COPY, 7, CHK_NONE);
        add_test(7, "ident_again", 8, 1'b0, 16'h0000, REF_COPY, 8, CHK_IDENT);
        add_test(8, "rand_len130", 130, 1'b0, 16'h0000, REF_RAND, 9, CHK_NONE);
    endtask

    task automatic make_stimulus(input int n);
        lcg_state = SEED + t_seed_ofs[n];
        for (int r = 0; r < sw_pkg::NUM_PE; r++) begin
            if (t_qfix[n]) begin
                qry[r] = t_qval[n][2*r +: 2];
            end else begin
                lcg_state = lcg_next(lcg_state);
                qry[r] = lcg_state[31:30];
            end
        end
        for (int c = 0; c < MAX_COLS; c++) begin
            lcg_state = lcg_next(lcg_state);
            if (c >= t_len[n]) begin
                refs[c] = '0;
            end else if (t_kind[n] == REF_COPY) begin
                refs[c] = (c < sw_pkg::NUM_PE) ? qry[c] : lcg_state[31:30];
            end else if (t_kind[n] == REF_MISS) begin
                refs[c] = sw_pkg::base_t'(1 + lcg_state[31:16] % 3);
            end else begin
                refs[c] = lcg_state[31:30];
            end
        end
    endtask

    task automatic report_mismatch(input string tname, input string field, input int exp,
                                   input int act);
        $display("[ERROR] %s %s expected %0d actual %0d", tname, field, exp, act);
    endtask

    task automatic run_test(input int n);
        int                                       e_score;
        int                                       e_row;
        int                                       e_col;
        int                                       e_diag;
        int                                       a_score;
        int                                       a_row;
        int                                       a_col;
        int                                       a_diag;
        int                                       k;
        int                                       waited;
        int                                       errs;
        bit                                       ended;
        logic [sw_pkg::NUM_PE*sw_pkg::BASE_W-1:0] b_packed;

        make_stimulus(n);
        align_model(qry, refs, t_len[n], e_score, e_row, e_col, e_diag);
        for (int r = 0; r < sw_pkg::NUM_PE; r++) begin
            b_packed[r*sw_pkg::BASE_W +: sw_pkg::BASE_W] = qry[r];
        end
        k      = 0;
        waited = 0;
        errs   = 0;
        ended  = 1'b0;
        // one base per cycle until the end pulse shows up
        while (!ended && waited < t_len[n] + sw_pkg::NUM_PE + 20) begin
            @(posedge i_clk);
            if (k < t_len[n]) begin
                i_start <= 1'b1;
                i_a     <= refs[k];
                i_b     <= b_packed;
                k++;
            end else begin
                i_start <= 1'b0;
            end
            @(negedge i_clk);
            ended  = o_stripe_end;
            waited++;
        end
        a_score = o_max_score;
        a_row   = o_max_row;
        a_col   = o_max_col;
        a_diag  = o_stop_diag;
        @(posedge i_clk);
        i_start <= 1'b0;

        if (!ended) begin
            $display("%s: no stripe end pulse within %0d cycles", t_name[n], waited);
            errs++;
        end else begin
            if (a_score != e_score) begin
                report_mismatch(t_name[n], "max_score", e_score, a_score);
                errs++;
            end
            if (a_row != e_row) begin
                report_mismatch(t_name[n], "max_row", e_row, a_row);
                errs++;
            end
            if (a_col != e_col) begin
                report_mismatch(t_name[n], "max_col", e_col, a_col);
                errs++;
            end
            if (a_diag != e_diag) begin
                report_mismatch(t_name[n], "stop_diag", e_diag, a_diag);
                errs++;
            end
            if (t_chk[n] == CHK_IDENT && a_score != sw_pkg::NUM_PE * sw_pkg::MATCH) begin
                report_mismatch(t_name[n], "ident score", sw_pkg::NUM_PE * sw_pkg::MATCH,
                                a_score);
                errs++;
            end
            if (t_chk[n] == CHK_IDENT && a_diag != 2 * sw_pkg::NUM_PE - 2) begin
                report_mismatch(t_name[n], "ident diag", 2 * sw_pkg::NUM_PE - 2, a_diag);
                errs++;
            end
            if (t_chk[n] == CHK_EARLY && a_diag >= t_len[n] + sw_pkg::NUM_PE - 2) begin
                $display("[ERROR] %s stop_diag expected below %0d actual %0d", t_name[n],
                         t_len[n] + sw_pkg::NUM_PE - 2, a_diag);
                errs++;
            end
        end
        if (errs == 0) begin
            n_pass++;
            $display("%s: passed, score %0d at row %0d col %0d, stop diag %0d", t_name[n],
                     a_score, a_row, a_col, a_diag);
        end else begin
            n_fail++;
            $display("%s: failed with %0d errors", t_name[n], errs);
        end
    endtask

    initial begin
        i_clk      = 1'b0;
        i_rst      = 1'b1;
        i_start    = 1'b0;
        i_a        = '0;
        i_b        = '0;
        n_pass     = 0;
        n_fail     = 0;
        reset_errs = 0;
        build_table();
        budget = RST_CYCLES;
        for (int n = 0; n < NUM_TESTS; n++) begin
            budget += t_len[n] + sw_pkg::NUM_PE + 20;
        end

        repeat (RST_CYCLES) @(posedge i_clk);
        i_rst <= 1'b0;
        @(negedge i_clk);
        if (o_stripe_end !== 1'b0) begin
            report_mismatch("reset_values", "stripe_end", 0, o_stripe_end);
            reset_errs++;
        end
        if (o_max_score !== sw_pkg::NEG_INF) begin
            report_mismatch("reset_values", "max_score", sw_pkg::NEG_INF, o_max_score);
            reset_errs++;
        end
        if (o_max_row !== '0) begin
            report_mismatch("reset_values", "max_row", 0, o_max_row);
            reset_errs++;
        end
        if (o_max_col !== '0) begin
            report_mismatch("reset_values", "max_col", 0, o_max_col);
            reset_errs++;
        end
        if (o_stop_diag !== '0) begin
            report_mismatch("reset_values", "stop_diag", 0, o_stop_diag);
            reset_errs++;
        end
        if (reset_errs != 0) begin
            n_fail++;
            $display("reset_values: failed with %0d errors", reset_errs);
        end else begin
            n_pass++;
            $display("reset_values: passed");
        end

        for (int n = 0; n < NUM_TESTS; n++) begin
            run_test(n);
        end

        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+tests
rtl/sw_pkg.sv
rtl/array_ctrl_if.sv
rtl/wavefront_if.sv
rtl/sw_pe.sv
rtl/sw_pe_array.sv
rtl/wavefront_max_tree.sv
rtl/stripe_ctrl.sv
rtl/sw_stripe_top.sv
tests/tb_sw_stripe.sv
